// ==== qamPkg.sv ====
`default_nettype none

package qamPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and FIFO sizing
	//////////////////////////////////////////////////////////////////////
	localparam int wordWidth       = 4;                       // Two Gray pairs per word
	localparam int levelWidth      = 4;                       // Signed I or Q sample
	localparam int fifoDepth       = 8;                       // Entries per FIFO
	localparam int ptrWidth        = $clog2(fifoDepth);       // Wraps naturally at depth 8
	localparam int countWidth      = $clog2(fifoDepth + 1);   // Fill count 0 to depth
	localparam int almostFullLevel = 6;                       // Two words may still be in flight

	//////////////////////////////////////////////////////////////////////
	// Constellation, Gray pairs and decision thresholds
	//////////////////////////////////////////////////////////////////////
	localparam logic signed [levelWidth-1:0] levelNeg3 = levelWidth'(-6);   // Outer negative
	localparam logic signed [levelWidth-1:0] levelNeg1 = levelWidth'(-2);
	localparam logic signed [levelWidth-1:0] levelPos1 = levelWidth'(2);
	localparam logic signed [levelWidth-1:0] levelPos3 = levelWidth'(6);    // Outer positive

	localparam logic [1:0] grayNeg3 = 2'b00;   // Adjacent levels differ in one bit
	localparam logic [1:0] grayNeg1 = 2'b01;
	localparam logic [1:0] grayPos1 = 2'b11;
	localparam logic [1:0] grayPos3 = 2'b10;

	localparam logic signed [levelWidth-1:0] threshLow  = levelWidth'(-4);  // Midpoint -6/-2
	localparam logic signed [levelWidth-1:0] threshMid  = levelWidth'(0);   // Midpoint -2/2
	localparam logic signed [levelWidth-1:0] threshHigh = levelWidth'(4);   // Midpoint 2/6

	// Signed range of one sample, used to clamp the channel sum
	localparam logic signed [levelWidth-1:0] satMax = levelWidth'((1 << (levelWidth - 1)) - 1);
	localparam logic signed [levelWidth-1:0] satMin = levelWidth'(-(1 << (levelWidth - 1)));

	//////////////////////////////////////////////////////////////////////
	// Symbol and mapper FSM types
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                         eoc;   // End of conversion, symbol valid
		logic signed [levelWidth-1:0] i;     // In-phase level
		logic signed [levelWidth-1:0] q;     // Quadrature level
	} qamSymbolT;

	typedef enum logic [1:0] {
		idle,    // Waiting for a word and room downstream
		fetch,   // Popped word held, levels computed
		emit     // EOC strobe out
	} mapStateT;

endpackage

`default_nettype wire

// ==== wordFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module wordFifo
	import qamPkg::*;
(
	input  logic                 inClock,
	input  logic                 arstN,
	input  logic                 push,        // Write strobe
	input  logic                 pop,         // Read strobe that removes the head word
	input  logic [wordWidth-1:0] pushData,
	output logic [wordWidth-1:0] popData,     // Head word valid while not empty
	output logic                 full,
	output logic                 almostFull,
	output logic                 empty
);

	//////////////////////////////////////////////////////////////////////
	// Storage and pointers
	//////////////////////////////////////////////////////////////////////
	logic [wordWidth-1:0]  mem [fifoDepth];   // Word array
	logic [ptrWidth-1:0]   wrPtr;             // Next free slot
	logic [ptrWidth-1:0]   rdPtr;             // Head slot
	logic [countWidth-1:0] count;             // Words stored
	logic                  doPush;
	logic                  doPop;

	assign doPush = push && !full;            // Write while full is dropped
	assign doPop  = pop && !empty;            // Read while empty does nothing

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;            // Wraps at depth
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: begin
					count <= count + 1'b1;        // Fill only
				end
				2'b01: begin
					count <= count - 1'b1;        // Drain only
				end
				default: begin
					count <= count;               // Both or neither
				end
			endcase
		end
	end

	always_ff @(posedge inClock) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Flags and read port
	//////////////////////////////////////////////////////////////////////
	assign popData    = mem[rdPtr];                                // Fall-through head
	assign full       = (count == countWidth'(fifoDepth));
	assign almostFull = (count >= countWidth'(almostFullLevel));   // Back-pressure level
	assign empty      = (count == '0);

	// The writer upstream sees full and must hold off
	assert property (@(posedge inClock) disable iff (!arstN) push |-> !full)
		else $error("wordFifo: push while full");

	// The reader sees empty before it pops
	assert property (@(posedge inClock) disable iff (!arstN) pop |-> !empty)
		else $error("wordFifo: pop while empty");

endmodule

`default_nettype wire

// ==== qamMapper.sv ====
`timescale 1ns/1ns
`default_nettype none

module qamMapper
	import qamPkg::*;
(
	input  logic                 inClock,
	input  logic                 arstN,
	input  logic [wordWidth-1:0] fifoData,    // Head of input FIFO
	input  logic                 fifoEmpty,
	input  logic                 stall,       // Output FIFO almost full
	output logic                 popIn,       // One-cycle pop pulse
	output qamSymbolT            txSymbol
);

	mapStateT                     state;
	logic [wordWidth-1:0]         wordReg;    // Word taken at the pop
	logic signed [levelWidth-1:0] iReg;
	logic signed [levelWidth-1:0] qReg;

	// Gray pair to constellation level on one axis
	function automatic logic signed [levelWidth-1:0] grayToLevel(input logic [1:0] pair);
		logic signed [levelWidth-1:0] level;
		case (pair)
			grayNeg3: level = levelNeg3;
			grayNeg1: level = levelNeg1;
			grayPos1: level = levelPos1;
			default:  level = levelPos3;         // 2'b10
		endcase
		return level;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Fetch FSM
	//////////////////////////////////////////////////////////////////////
	assign popIn = (state == idle) && !fifoEmpty && !stall;   // Only with room downstream

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (popIn) begin
						state <= fetch;
					end
				end
				fetch: begin
					state <= emit;                 // Levels latched this edge
				end
				emit: begin
					state <= idle;                 // Next pop at the earliest
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge inClock) begin
		if (popIn) begin
			wordReg <= fifoData;
		end
		if (state == fetch) begin
			iReg <= grayToLevel(wordReg[wordWidth-1 -: 2]);   // Bits 3:2 to I
			qReg <= grayToLevel(wordReg[1:0]);                // Bits 1:0 to Q
		end
	end

	assign txSymbol = '{eoc: (state == emit), i: iReg, q: qReg};

	assert property (@(posedge inClock) disable iff (!arstN) txSymbol.eoc |=> !txSymbol.eoc)
		else $error("qamMapper: EOC held two cycles");

endmodule

`default_nettype wire

// ==== qamSlicer.sv ====
`timescale 1ns/1ns
`default_nettype none

module qamSlicer
	import qamPkg::*;
(
	input  logic                         inClock,
	input  logic                         arstN,
	input  qamSymbolT                    rxSymbol,   // Symbol from the mapper
	input  logic signed [levelWidth-1:0] iOffset,    // Channel offset on I
	input  logic signed [levelWidth-1:0] qOffset,    // Channel offset on Q
	output logic [wordWidth-1:0]         rxWord,     // Recovered word
	output logic                         pushOut     // One cycle after EOC
);

	logic signed [levelWidth-1:0] iSum;   // Received I after channel
	logic signed [levelWidth-1:0] qSum;
	logic [1:0]                   iBits;  // Decided Gray pair
	logic [1:0]                   qBits;

	//////////////////////////////////////////////////////////////////////
	// Channel model
	//////////////////////////////////////////////////////////////////////
	function automatic logic signed [levelWidth-1:0] satAdd(
		input logic signed [levelWidth-1:0] a,
		input logic signed [levelWidth-1:0] b
	);
		logic signed [levelWidth:0]   wide;      // One guard bit
		logic signed [levelWidth-1:0] result;
		wide = (levelWidth + 1)'(a) + (levelWidth + 1)'(b);   // Sign-extended sum
		if (wide > (levelWidth + 1)'(satMax)) begin
			result = satMax;                     // Clamp high
		end else if (wide < (levelWidth + 1)'(satMin)) begin
			result = satMin;                     // Clamp low
		end else begin
			result = wide[levelWidth-1:0];
		end
		return result;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Decision
	//////////////////////////////////////////////////////////////////////
	// Nearest level by the midpoint thresholds and back to its Gray pair
	function automatic logic [1:0] sliceToGray(input logic signed [levelWidth-1:0] sample);
		logic [1:0] pair;
		if (sample < threshLow) begin
			pair = grayNeg3;
		end else if (sample < threshMid) begin
			pair = grayNeg1;
		end else if (sample < threshHigh) begin
			pair = grayPos1;
		end else begin
			pair = grayPos3;                     // Saturated sums land here
		end
		return pair;
	endfunction

	assign iSum  = satAdd(rxSymbol.i, iOffset);
	assign qSum  = satAdd(rxSymbol.q, qOffset);
	assign iBits = sliceToGray(iSum);
	assign qBits = sliceToGray(qSum);

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			pushOut <= 1'b0;
		end else begin
			pushOut <= rxSymbol.eoc;             // Push follows strobe
		end
	end

	always_ff @(posedge inClock) begin
		if (rxSymbol.eoc) begin
			rxWord <= {iBits, qBits};            // I pair in high bits
		end
	end

	// Strobes from the mapper are spaced, so pushes never run back to back
	assert property (@(posedge inClock) disable iff (!arstN) pushOut |=> !pushOut)
		else $error("qamSlicer: back-to-back push");

endmodule

`default_nettype wire

// ==== qamLoopback.sv ====
`timescale 1ns/1ns
`default_nettype none

module qamLoopback
	import qamPkg::*;
(
	input  logic                         inClock,
	input  logic                         arstN,
	input  logic [wordWidth-1:0]         inData,        // Word to send
	input  logic                         writeEnable,
	input  logic                         readEnable,
	input  logic signed [levelWidth-1:0] iOffset,       // Channel noise on I
	input  logic signed [levelWidth-1:0] qOffset,       // Channel noise on Q
	output logic [wordWidth-1:0]         outData,       // Head of output FIFO
	output logic                         inFull,
	output logic                         outEmpty
);

	//////////////////////////////////////////////////////////////////////
	// Pipeline nets
	//////////////////////////////////////////////////////////////////////
	logic                 inPush;          // Write that is kept
	logic                 outPop;          // Read that has data
	logic [wordWidth-1:0] headWord;        // Input FIFO to mapper
	logic                 inEmpty;
	logic                 popIn;
	qamSymbolT            txSymbol;        // Mapper to slicer
	logic [wordWidth-1:0] rxWord;          // Slicer to output FIFO
	logic                 pushOut;
	logic                 outAlmostFull;   // Stall back to mapper

	assign inPush = writeEnable && !inFull;   // Write while full is dropped
	assign outPop = readEnable && !outEmpty;

	wordFifo inFifo (
		.inClock    (inClock),
		.arstN      (arstN),
		.push       (inPush),
		.pop        (popIn),
		.pushData   (inData),
		.popData    (headWord),
		.full       (inFull),
		.almostFull (),
		.empty      (inEmpty)
	);

	qamMapper mapper (
		.inClock   (inClock),
		.arstN     (arstN),
		.fifoData  (headWord),
		.fifoEmpty (inEmpty),
		.stall     (outAlmostFull),
		.popIn     (popIn),
		.txSymbol  (txSymbol)
	);

	qamSlicer slicer (
		.inClock  (inClock),
		.arstN    (arstN),
		.rxSymbol (txSymbol),
		.iOffset  (iOffset),
		.qOffset  (qOffset),
		.rxWord   (rxWord),
		.pushOut  (pushOut)
	);

	wordFifo outFifo (
		.inClock    (inClock),
		.arstN      (arstN),
		.push       (pushOut),
		.pop        (outPop),
		.pushData   (rxWord),
		.popData    (outData),
		.full       (),
		.almostFull (outAlmostFull),   // Room kept for two in flight
		.empty      (outEmpty)
	);

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClockGen (
	output logic inClock   // Free-running testbench clock
);

	localparam int halfPeriod = 10;   // 20 ns period

	initial begin
		inClock = 1'b0;
		forever begin
			#halfPeriod inClock = ~inClock;
		end
	end

endmodule

`default_nettype wire

// ==== tbQamLoopback.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbQamLoopback
	import qamPkg::*;
();

	localparam int fullLimit  = 200;   // Cycles to wait for room in the input FIFO
	localparam int drainLimit = 600;   // Cycles to empty the pipeline
	localparam int stallLimit = 100;   // Cycles until back-pressure engages
	localparam int idleWindow = 30;    // Quiet cycles after the overflow drain

	logic                         inClock;
	logic                         arstN;
	logic [wordWidth-1:0]         inData;
	logic                         writeEnable;
	logic                         readEnable;
	logic signed [levelWidth-1:0] iOffset;
	logic signed [levelWidth-1:0] qOffset;
	logic [wordWidth-1:0]         outData;
	logic                         inFull;
	logic                         outEmpty;

	logic [wordWidth-1:0] expectQ [$];   // Words due at outData, oldest first
	logic                 drainOn;       // Checker may read the output FIFO
	int                   errorCount;
	int                   checkCount;
	int                   curIOff;       // Offsets now on the channel
	int                   curQOff;

	tbClockGen clockGen (.inClock(inClock));

	qamLoopback DUT (
		.inClock     (inClock),
		.arstN       (arstN),
		.inData      (inData),
		.writeEnable (writeEnable),
		.readEnable  (readEnable),
		.iOffset     (iOffset),
		.qOffset     (qOffset),
		.outData     (outData),
		.inFull      (inFull),
		.outEmpty    (outEmpty)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	// Level order -6, -2, 2, 6 as index 0 to 3
	function automatic logic [1:0] pairAtIndex(input int idx);
		logic [1:0] pair;
		case (idx)
			0:       pair = 2'b00;
			1:       pair = 2'b01;
			2:       pair = 2'b11;
			default: pair = 2'b10;
		endcase
		return pair;
	endfunction

	// One axis through channel and decision
	function automatic logic [1:0] decideAxis(input logic [1:0] pair, input int offset);
		int idx;
		int k;
		int sample;
		int maxSample;
		idx       = 0;
		maxSample = (1 << (levelWidth - 1)) - 1;
		for (k = 0; k < 4; k++) begin
			if (pairAtIndex(k) == pair) begin
				idx = k;
			end
		end
		sample = 4 * idx - 6 + offset;               // Level spacing of 4
		if (sample > maxSample) begin
			sample = maxSample;                       // Saturate high
		end
		if (sample < -maxSample - 1) begin
			sample = -maxSample - 1;                  // Saturate low
		end
		return pairAtIndex((sample + maxSample + 1) / 4);   // Bins split at -4, 0, 4
	endfunction

	function automatic logic [wordWidth-1:0] expectWord(
		input logic [wordWidth-1:0] word,
		input int                   iOff,
		input int                   qOff
	);
		logic [wordWidth-1:0] result;
		result = {decideAxis(word[3:2], iOff), decideAxis(word[1:0], qOff)};
		return result;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	task automatic abortRun(input string what);
		$display("Timeout: %s", what);
		$display("errors: %0d, checks: %0d", errorCount + 1, checkCount);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		checkCount++;
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic setOffsets(input int iOff, input int qOff);
		curIOff = iOff;
		curQOff = qOff;
		iOffset = levelWidth'(iOff);
		qOffset = levelWidth'(qOff);
	endtask

	// Writer that respects inFull
	task automatic writeWord(input logic [wordWidth-1:0] word);
		int waited;
		waited = 0;
		while (inFull && waited < fullLimit) begin
			@(negedge inClock);
			waited++;
		end
		if (inFull) begin
			abortRun("input FIFO stayed full");
		end else begin
			inData      = word;
			writeEnable = 1'b1;
			expectQ.push_back(expectWord(word, curIOff, curQOff));
			@(negedge inClock);
			writeEnable = 1'b0;
		end
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && waited < drainLimit) begin
			@(negedge inClock);
			waited++;
		end
		if (expectQ.size() != 0) begin
			abortRun($sformatf("%0d words never reached outData", expectQ.size()));
		end
	endtask

	// Mapper stall flag inside the DUT
	task automatic waitStall();
		int waited;
		waited = 0;
		while (!DUT.outAlmostFull && waited < stallLimit) begin
			@(negedge inClock);
			waited++;
		end
		if (!DUT.outAlmostFull) begin
			abortRun("output FIFO never reached the almost-full level");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output checker
	//////////////////////////////////////////////////////////////////////
	initial begin : compareOutput
		logic [wordWidth-1:0] expected;
		readEnable = 1'b0;
		forever begin
			@(negedge inClock);
			readEnable = 1'b0;
			if (drainOn && !outEmpty) begin
				if (expectQ.size() == 0) begin
					$display("Unexpected word %h at outData at %0t", outData, $time);
					errorCount++;
				end else begin
					expected = expectQ.pop_front();
					checkCount++;
					if (outData !== expected) begin
						$display("ERROR at %0t: outData is %h, expected %h",
							$time, outData, expected);
						errorCount++;
					end
				end
				readEnable = 1'b1;                   // Pop on the next rising edge
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		int k;
		int round;
		void'($urandom(32'h3ee8));
		arstN       = 1'b0;
		inData      = '0;
		writeEnable = 1'b0;
		drainOn     = 1'b0;
		errorCount  = 0;
		checkCount  = 0;
		setOffsets(0, 0);
		repeat (16) @(negedge inClock);
		arstN = 1'b1;

		checkFlag("outEmpty", outEmpty, 1'b1);   // Flags out of reset
		checkFlag("inFull", inFull, 1'b0);

		drainOn = 1'b1;
		for (k = 0; k < 16; k++) begin
			writeWord(wordWidth'(k));                // Every constellation point
		end
		waitDrained();

		for (round = 0; round < 8; round++) begin
			setOffsets(int'($urandom_range(2, 0)) - 1, int'($urandom_range(2, 0)) - 1);
			for (k = 0; k < 6; k++) begin
				writeWord(wordWidth'($urandom_range(15, 0)));
			end
			waitDrained();                           // Offsets change only when empty
		end

		// Fill the output FIFO up to the stall, then overflow the input FIFO
		setOffsets(0, 0);
		drainOn = 1'b0;
		for (k = 0; k < almostFullLevel; k++) begin
			writeWord(wordWidth'(k));
		end
		waitStall();
		for (k = 0; k <= fifoDepth; k++) begin
			checkFlag("inFull", inFull, (k == fifoDepth) ? 1'b1 : 1'b0);
			inData      = wordWidth'(15 - k);
			writeEnable = 1'b1;
			if (k < fifoDepth) begin
				expectQ.push_back(expectWord(wordWidth'(15 - k), curIOff, curQOff));
			end
			@(negedge inClock);
		end
		writeEnable = 1'b0;
		checkFlag("inFull", inFull, 1'b1);
		drainOn = 1'b1;
		waitDrained();
		repeat (idleWindow) @(negedge inClock);   // Dropped word must not show up
		checkFlag("inFull", inFull, 1'b0);
		checkFlag("outEmpty", outEmpty, 1'b1);

		setOffsets(3, 0);                            // Pushes I across one threshold
		for (k = 0; k < 16; k++) begin
			writeWord(wordWidth'(k));
		end
		waitDrained();

		$display("errors: %0d, checks: %0d", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== qamLoopback.f ====
qamPkg.sv
wordFifo.sv
qamMapper.sv
qamSlicer.sv
qamLoopback.sv
tbClockGen.sv
tbQamLoopback.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbQamLoopback
FILELIST = qamLoopback.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
